// File: hdl/core_pkg.sv
package core_pkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0] xlen_t;                     // Data word
    typedef logic [XLEN-1:0] addr_t;                     // Byte address
    typedef logic [31:0]     instr_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

    // Where decode takes a source operand from
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_EXE = 2'd1,
        FWD_MEM = 2'd2,
        FWD_WB  = 2'd3
    } fwd_sel_e;

    // Cleared values
    localparam xlen_t    ZERO_WORD = '0;
    localparam reg_idx_t ZERO_REG  = '0;                 // Hardwired zero register x0

endpackage

// File: hdl/isa_pkg.sv
package isa_pkg;

    typedef logic [6:0] funct7_t;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 fields
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_LW_SW   = 3'b010;              // Word size only

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // Stage that raised the trap
    typedef enum logic [1:0] {
        CAUSE_FETCH   = 2'd0,
        CAUSE_DECODE  = 2'd1,
        CAUSE_EXECUTE = 2'd2,
        CAUSE_MEMORY  = 2'd3
    } cause_e;

endpackage

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter core_pkg::addr_t BOOT_ADDRESS = 32'h0000_0000
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_hold,
    input  logic             i_branch_taken,
    input  core_pkg::addr_t  i_target_pc,
    input  core_pkg::instr_t i_imem_data,
    output core_pkg::addr_t  o_imem_addr,
    output core_pkg::instr_t o_instr,
    output core_pkg::addr_t  o_pc,
    output logic             o_valid
);

    core_pkg::addr_t pc;

    assign o_imem_addr = pc;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            pc      <= BOOT_ADDRESS;
            o_valid <= 1'b0;
        end
        else if (!i_hold)
        begin
            pc      <= i_branch_taken ? i_target_pc : pc + 32'd4;
            o_valid <= !i_branch_taken;                  // Wrong-path word dropped
        end
    end

    // F/D payload
    always_ff @(posedge i_clk)
    begin
        if (!i_hold)
        begin
            o_instr <= i_imem_data;
            o_pc    <= pc;
        end
    end

    // Branch targets must land on word boundaries too
    a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        o_imem_addr[1:0] == 2'b00);

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_hold,
    input  logic               i_bubble,
    input  logic               i_branch_taken,
    input  core_pkg::instr_t   i_instr,
    input  core_pkg::addr_t    i_pc,
    input  logic               i_valid,
    input  core_pkg::fwd_sel_e i_fwd_rs1,
    input  core_pkg::fwd_sel_e i_fwd_rs2,
    input  core_pkg::xlen_t    i_exe_result,
    input  core_pkg::xlen_t    i_mem_result,
    input  logic               i_wb_en,
    input  core_pkg::reg_idx_t i_wb_rd,
    input  core_pkg::xlen_t    i_wb_data,
    output core_pkg::reg_idx_t o_rs1,
    output core_pkg::reg_idx_t o_rs2,
    output logic               o_use_rs1,
    output logic               o_use_rs2,
    output isa_pkg::alu_op_e   o_alu_op,
    output core_pkg::xlen_t    o_op_a,
    output core_pkg::xlen_t    o_op_b,
    output core_pkg::xlen_t    o_store_data,
    output core_pkg::reg_idx_t o_rd,
    output logic               o_rd_wr,
    output logic               o_is_load,
    output logic               o_is_store,
    output logic               o_is_branch,
    output logic               o_branch_ne,
    output logic               o_is_ecall,
    output logic               o_trap_illegal,
    output core_pkg::addr_t    o_pc,
    output logic               o_valid
);

    core_pkg::xlen_t regs [core_pkg::REG_COUNT];
    core_pkg::xlen_t rs1_rf, rs2_rf, rs1_val, rs2_val, imm;
    core_pkg::xlen_t imm_i, imm_s, imm_b;
    isa_pkg::funct7_t funct7;
    isa_pkg::alu_op_e alu_op;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic is_op, is_addi, is_lw, is_sw, is_br, is_ec, legal;
    logic [6:0] ctrl_next, ctrl_q;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};

    // Write-back port never writes x0
    always_ff @(posedge i_clk)
    begin
        if (i_wb_en && i_wb_rd != core_pkg::ZERO_REG)
            regs[i_wb_rd] <= i_wb_data;
    end

    assign rs1_rf = (o_rs1 == core_pkg::ZERO_REG) ? core_pkg::ZERO_WORD : regs[o_rs1];
    assign rs2_rf = (o_rs2 == core_pkg::ZERO_REG) ? core_pkg::ZERO_WORD : regs[o_rs2];

    always_comb
    begin
        case (i_fwd_rs1)
            core_pkg::FWD_EXE: rs1_val = i_exe_result;
            core_pkg::FWD_MEM: rs1_val = i_mem_result;
            core_pkg::FWD_WB:  rs1_val = i_wb_data;
            default:           rs1_val = rs1_rf;
        endcase
        case (i_fwd_rs2)
            core_pkg::FWD_EXE: rs2_val = i_exe_result;
            core_pkg::FWD_MEM: rs2_val = i_mem_result;
            core_pkg::FWD_WB:  rs2_val = i_wb_data;
            default:           rs2_val = rs2_rf;
        endcase
    end

    // Supported encodings
    assign is_op   = opcode == isa_pkg::OPC_OP &&
                     ((funct7 == isa_pkg::F7_BASE && funct3 inside {isa_pkg::F3_ADD_SUB,
                       isa_pkg::F3_XOR, isa_pkg::F3_OR, isa_pkg::F3_AND}) ||
                      (funct7 == isa_pkg::F7_SUB && funct3 == isa_pkg::F3_ADD_SUB));
    assign is_addi = opcode == isa_pkg::OPC_OP_IMM && funct3 == isa_pkg::F3_ADD_SUB;
    assign is_lw   = opcode == isa_pkg::OPC_LOAD && funct3 == isa_pkg::F3_LW_SW;
    assign is_sw   = opcode == isa_pkg::OPC_STORE && funct3 == isa_pkg::F3_LW_SW;
    assign is_br   = opcode == isa_pkg::OPC_BRANCH &&
                     (funct3 == isa_pkg::F3_BEQ || funct3 == isa_pkg::F3_BNE);
    assign is_ec   = opcode == isa_pkg::OPC_SYSTEM && i_instr[31:7] == '0;
    assign legal   = is_op || is_addi || is_lw || is_sw || is_br || is_ec;

    assign o_use_rs1 = i_valid && (is_op || is_addi || is_lw || is_sw || is_br);
    assign o_use_rs2 = i_valid && (is_op || is_sw || is_br);

    assign imm = is_sw ? imm_s : (is_br ? imm_b : imm_i);

    always_comb
    begin
        case (funct3)
            isa_pkg::F3_XOR: alu_op = isa_pkg::ALU_XOR;
            isa_pkg::F3_OR:  alu_op = isa_pkg::ALU_OR;
            isa_pkg::F3_AND: alu_op = isa_pkg::ALU_AND;
            default:         alu_op = funct7[5] ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
        endcase
        if (!is_op)
            alu_op = isa_pkg::ALU_ADD;                   // ADDI and address paths add
    end

    // valid, rd_wr, load, store, branch, ecall, illegal
    assign ctrl_next = i_valid ? {1'b1, is_op || is_addi || is_lw, is_lw, is_sw, is_br,
                                  is_ec, !legal} : '0;
    assign {o_valid, o_rd_wr, o_is_load, o_is_store, o_is_branch, o_is_ecall,
            o_trap_illegal} = ctrl_q;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            ctrl_q <= '0;
        else if (i_bubble)
            ctrl_q <= '0;                                // Load-use empty slot
        else if (!i_hold)
            ctrl_q <= i_branch_taken ? '0 : ctrl_next;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_hold)
        begin
            o_alu_op     <= alu_op;
            o_op_a       <= rs1_val;
            o_op_b       <= is_op ? rs2_val : imm;       // Branch offset rides here
            o_store_data <= rs2_val;
            o_rd         <= i_instr[11:7];
            o_branch_ne  <= funct3 == isa_pkg::F3_BNE;
            o_pc         <= i_pc;
        end
    end

    // The load leaves execute right after its bubble
    a_one_bubble: assert property (@(posedge i_clk) disable iff (i_rst)
        i_bubble |=> !i_bubble);

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  core_pkg::reg_idx_t i_rs1,
    input  core_pkg::reg_idx_t i_rs2,
    input  logic               i_use_rs1,
    input  logic               i_use_rs2,
    input  core_pkg::reg_idx_t i_exe_rd,
    input  logic               i_exe_rd_wr,
    input  logic               i_exe_is_load,
    input  core_pkg::reg_idx_t i_mem_rd,
    input  logic               i_mem_rd_wr,
    input  core_pkg::reg_idx_t i_wb_rd,
    input  logic               i_wb_en,
    input  logic               i_mem_stall,
    output core_pkg::fwd_sel_e o_fwd_rs1,
    output core_pkg::fwd_sel_e o_fwd_rs2,
    output logic               o_bubble,
    output logic               o_hold_front,
    output logic               o_hold_exe
);

    logic exe_hit1, exe_hit2, mem_hit1, mem_hit2, wb_hit1, wb_hit2, load_use;

    function automatic logic hit(input logic use_src, input core_pkg::reg_idx_t src,
                                 input logic wr, input core_pkg::reg_idx_t dst);
        return use_src && wr && src == dst && src != core_pkg::ZERO_REG;
    endfunction

    // Nearest producer wins
    function automatic core_pkg::fwd_sel_e pick(input logic e, input logic m, input logic w);
        if (e)
            return core_pkg::FWD_EXE;
        if (m)
            return core_pkg::FWD_MEM;
        return w ? core_pkg::FWD_WB : core_pkg::FWD_RF;
    endfunction

    assign exe_hit1 = hit(i_use_rs1, i_rs1, i_exe_rd_wr, i_exe_rd);
    assign exe_hit2 = hit(i_use_rs2, i_rs2, i_exe_rd_wr, i_exe_rd);
    assign mem_hit1 = hit(i_use_rs1, i_rs1, i_mem_rd_wr, i_mem_rd);
    assign mem_hit2 = hit(i_use_rs2, i_rs2, i_mem_rd_wr, i_mem_rd);
    assign wb_hit1  = hit(i_use_rs1, i_rs1, i_wb_en, i_wb_rd);
    assign wb_hit2  = hit(i_use_rs2, i_rs2, i_wb_en, i_wb_rd);

    assign o_fwd_rs1 = pick(exe_hit1, mem_hit1, wb_hit1);
    assign o_fwd_rs2 = pick(exe_hit2, mem_hit2, wb_hit2);

    assign load_use = i_exe_is_load && (exe_hit1 || exe_hit2);   // Data not back yet

    // While memory waits the whole front holds, so no bubble
    assign o_bubble     = load_use && !i_mem_stall;
    assign o_hold_front = load_use || i_mem_stall;
    assign o_hold_exe   = i_mem_stall;

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_hold,
    input  isa_pkg::alu_op_e   i_alu_op,
    input  core_pkg::xlen_t    i_op_a,
    input  core_pkg::xlen_t    i_op_b,
    input  core_pkg::xlen_t    i_store_data,
    input  core_pkg::reg_idx_t i_rd,
    input  logic               i_rd_wr,
    input  logic               i_is_load,
    input  logic               i_is_store,
    input  logic               i_is_branch,
    input  logic               i_branch_ne,
    input  logic               i_is_ecall,
    input  logic               i_trap_illegal,
    input  core_pkg::addr_t    i_pc,
    input  logic               i_valid,
    output core_pkg::xlen_t    o_result,
    output logic               o_branch_taken,
    output core_pkg::addr_t    o_target_pc,
    output core_pkg::xlen_t    o_mem_addr,
    output core_pkg::xlen_t    o_store_data,
    output core_pkg::reg_idx_t o_rd,
    output logic               o_rd_wr,
    output logic               o_is_load,
    output logic               o_is_store,
    output logic               o_is_ecall,
    output logic               o_trap_illegal,
    output core_pkg::addr_t    o_pc,
    output logic               o_valid
);

    logic [5:0] ctrl_q;

    always_comb
    begin
        case (i_alu_op)
            isa_pkg::ALU_SUB: o_result = i_op_a - i_op_b;
            isa_pkg::ALU_AND: o_result = i_op_a & i_op_b;
            isa_pkg::ALU_OR:  o_result = i_op_a | i_op_b;
            isa_pkg::ALU_XOR: o_result = i_op_a ^ i_op_b;
            default:          o_result = i_op_a + i_op_b;
        endcase
    end

    // rs2 of a branch arrives on the store data path
    assign o_branch_taken = i_valid && i_is_branch &&
                            ((i_op_a == i_store_data) != i_branch_ne);
    assign o_target_pc    = i_pc + i_op_b;

    assign {o_valid, o_rd_wr, o_is_load, o_is_store, o_is_ecall, o_trap_illegal} = ctrl_q;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            ctrl_q <= '0;
        else if (!i_hold)
            ctrl_q <= {i_valid, i_rd_wr, i_is_load, i_is_store, i_is_ecall, i_trap_illegal};
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_hold)
        begin
            o_mem_addr   <= o_result;                    // Address or ALU result
            o_store_data <= i_store_data;
            o_rd         <= i_rd;
            o_pc         <= i_pc;
        end
    end

endmodule

// File: hdl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage #(
    parameter core_pkg::addr_t BOOT_ADDRESS = 32'h0000_0000
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  core_pkg::xlen_t    i_mem_addr,
    input  core_pkg::xlen_t    i_store_data,
    input  core_pkg::reg_idx_t i_rd,
    input  logic               i_rd_wr,
    input  logic               i_is_load,
    input  logic               i_is_store,
    input  logic               i_is_ecall,
    input  logic               i_trap_illegal,
    input  core_pkg::addr_t    i_pc,
    input  logic               i_valid,
    input  core_pkg::xlen_t    i_dmem_rdata,
    input  logic               i_dmem_done,
    output logic               o_dmem_en,
    output logic               o_dmem_wr,
    output core_pkg::addr_t    o_dmem_addr,
    output core_pkg::xlen_t    o_dmem_wdata,
    output logic               o_mem_stall,
    output core_pkg::xlen_t    o_mem_result,
    output core_pkg::reg_idx_t o_rd,
    output logic               o_rd_wr,
    output logic               o_wb_en,
    output core_pkg::reg_idx_t o_wb_rd,
    output core_pkg::xlen_t    o_wb_data,
    output logic               o_ecall,
    output core_pkg::addr_t    o_epc,
    output isa_pkg::cause_e    o_cause
);

    logic access, misaligned, trap;

    assign access     = i_valid && (i_is_load || i_is_store);
    assign misaligned = access && i_mem_addr[1:0] != 2'b00;
    assign trap       = i_valid && (i_trap_illegal || misaligned);

    // Request held open by the execute hold until done
    assign o_dmem_en    = access && !trap;
    assign o_dmem_wr    = i_is_store;
    assign o_dmem_addr  = i_mem_addr;
    assign o_dmem_wdata = i_store_data;
    assign o_mem_stall  = o_dmem_en && !i_dmem_done;

    assign o_mem_result = i_is_load ? i_dmem_rdata : i_mem_addr;
    assign o_rd         = i_rd;
    assign o_rd_wr      = i_valid && i_rd_wr && !trap;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            o_wb_en <= 1'b0;
            o_ecall <= 1'b0;
            o_epc   <= BOOT_ADDRESS;
            o_cause <= isa_pkg::CAUSE_FETCH;
        end
        else
        begin
            o_wb_en <= o_rd_wr && !o_mem_stall;          // Empty slot while waiting
            o_ecall <= i_valid && i_is_ecall;
            if (trap)
            begin
                o_epc   <= i_pc;
                o_cause <= i_trap_illegal ? isa_pkg::CAUSE_DECODE : isa_pkg::CAUSE_MEMORY;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_wb_rd   <= i_rd;
        o_wb_data <= o_mem_result;
    end

    a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        o_mem_stall |=> o_dmem_en && $stable(o_dmem_addr) && $stable(o_dmem_wr) &&
                        $stable(o_dmem_wdata));

endmodule

// File: hdl/core.sv
`timescale 1ns/1ps

module core #(
    parameter core_pkg::addr_t BOOT_ADDRESS = 32'h0000_0000
) (
    input  logic             i_clk,
    input  logic             i_rst,
    output core_pkg::addr_t  o_imem_addr,
    input  core_pkg::instr_t i_imem_data,
    output logic             o_dmem_en,
    output logic             o_dmem_wr,
    output core_pkg::addr_t  o_dmem_addr,
    output core_pkg::xlen_t  o_dmem_wdata,
    input  core_pkg::xlen_t  i_dmem_rdata,
    input  logic             i_dmem_done,
    output logic             o_ecall,
    output core_pkg::addr_t  o_epc,
    output isa_pkg::cause_e  o_cause
);

    // Hazard and redirect
    logic hold_front, hold_exe, bubble, branch_taken;
    core_pkg::addr_t target_pc;
    core_pkg::fwd_sel_e fwd_rs1, fwd_rs2;

    core_pkg::instr_t fd_instr;
    core_pkg::addr_t fd_pc;
    logic fd_valid;

    // Decode sources and D/E
    core_pkg::reg_idx_t rs1, rs2, de_rd;
    logic use_rs1, use_rs2;
    isa_pkg::alu_op_e de_alu_op;
    core_pkg::xlen_t de_op_a, de_op_b, de_store_data;
    core_pkg::addr_t de_pc;
    logic de_rd_wr, de_is_load, de_is_store, de_is_branch, de_branch_ne, de_is_ecall;
    logic de_trap_illegal, de_valid;

    // E/M
    core_pkg::xlen_t exe_result, em_mem_addr, em_store_data;
    core_pkg::reg_idx_t em_rd;
    core_pkg::addr_t em_pc;
    logic em_rd_wr, em_is_load, em_is_store, em_is_ecall, em_trap_illegal, em_valid;

    // Memory and write-back
    core_pkg::xlen_t mem_result, wb_data;
    core_pkg::reg_idx_t mem_rd, wb_rd;
    logic mem_stall, mem_rd_wr, wb_en;

    fetch_stage #(.BOOT_ADDRESS(BOOT_ADDRESS)) u_fetch (
        .i_clk(i_clk), .i_rst(i_rst), .i_hold(hold_front),
        .i_branch_taken(branch_taken), .i_target_pc(target_pc), .i_imem_data(i_imem_data),
        .o_imem_addr(o_imem_addr), .o_instr(fd_instr), .o_pc(fd_pc), .o_valid(fd_valid)
    );

    decode_stage u_decode (
        .i_clk(i_clk), .i_rst(i_rst), .i_hold(hold_front), .i_bubble(bubble),
        .i_branch_taken(branch_taken), .i_instr(fd_instr), .i_pc(fd_pc), .i_valid(fd_valid),
        .i_fwd_rs1(fwd_rs1), .i_fwd_rs2(fwd_rs2),
        .i_exe_result(exe_result), .i_mem_result(mem_result),
        .i_wb_en(wb_en), .i_wb_rd(wb_rd), .i_wb_data(wb_data),
        .o_rs1(rs1), .o_rs2(rs2), .o_use_rs1(use_rs1), .o_use_rs2(use_rs2),
        .o_alu_op(de_alu_op), .o_op_a(de_op_a), .o_op_b(de_op_b),
        .o_store_data(de_store_data), .o_rd(de_rd), .o_rd_wr(de_rd_wr),
        .o_is_load(de_is_load), .o_is_store(de_is_store), .o_is_branch(de_is_branch),
        .o_branch_ne(de_branch_ne), .o_is_ecall(de_is_ecall),
        .o_trap_illegal(de_trap_illegal), .o_pc(de_pc), .o_valid(de_valid)
    );

    hazard_unit u_hazard (
        .i_rs1(rs1), .i_rs2(rs2), .i_use_rs1(use_rs1), .i_use_rs2(use_rs2),
        .i_exe_rd(de_rd), .i_exe_rd_wr(de_rd_wr), .i_exe_is_load(de_is_load),
        .i_mem_rd(mem_rd), .i_mem_rd_wr(mem_rd_wr), .i_wb_rd(wb_rd), .i_wb_en(wb_en),
        .i_mem_stall(mem_stall), .o_fwd_rs1(fwd_rs1), .o_fwd_rs2(fwd_rs2),
        .o_bubble(bubble), .o_hold_front(hold_front), .o_hold_exe(hold_exe)
    );

    execute_stage u_execute (
        .i_clk(i_clk), .i_rst(i_rst), .i_hold(hold_exe),
        .i_alu_op(de_alu_op), .i_op_a(de_op_a), .i_op_b(de_op_b),
        .i_store_data(de_store_data), .i_rd(de_rd), .i_rd_wr(de_rd_wr),
        .i_is_load(de_is_load), .i_is_store(de_is_store), .i_is_branch(de_is_branch),
        .i_branch_ne(de_branch_ne), .i_is_ecall(de_is_ecall),
        .i_trap_illegal(de_trap_illegal), .i_pc(de_pc), .i_valid(de_valid),
        .o_result(exe_result), .o_branch_taken(branch_taken), .o_target_pc(target_pc),
        .o_mem_addr(em_mem_addr), .o_store_data(em_store_data), .o_rd(em_rd),
        .o_rd_wr(em_rd_wr), .o_is_load(em_is_load), .o_is_store(em_is_store),
        .o_is_ecall(em_is_ecall), .o_trap_illegal(em_trap_illegal), .o_pc(em_pc),
        .o_valid(em_valid)
    );

    memory_stage #(.BOOT_ADDRESS(BOOT_ADDRESS)) u_memory (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_mem_addr(em_mem_addr), .i_store_data(em_store_data), .i_rd(em_rd),
        .i_rd_wr(em_rd_wr), .i_is_load(em_is_load), .i_is_store(em_is_store),
        .i_is_ecall(em_is_ecall), .i_trap_illegal(em_trap_illegal), .i_pc(em_pc),
        .i_valid(em_valid), .i_dmem_rdata(i_dmem_rdata), .i_dmem_done(i_dmem_done),
        .o_dmem_en(o_dmem_en), .o_dmem_wr(o_dmem_wr), .o_dmem_addr(o_dmem_addr),
        .o_dmem_wdata(o_dmem_wdata), .o_mem_stall(mem_stall), .o_mem_result(mem_result),
        .o_rd(mem_rd), .o_rd_wr(mem_rd_wr),
        .o_wb_en(wb_en), .o_wb_rd(wb_rd), .o_wb_data(wb_data),
        .o_ecall(o_ecall), .o_epc(o_epc), .o_cause(o_cause)
    );

endmodule

// File: dv/core_tb_program.svh
`ifndef CORE_TB_PROGRAM_SVH
`define CORE_TB_PROGRAM_SVH

// Program image, expected data words and protected words
task automatic load_program();
    int k;
    for (k = 0; k < IMEM_WORDS; k++)
        imem[k] = NOP;
    prog_len = 0;
    emit(encode_addi(5'd1, 5'd0, 12'h123));              // x1 = 0x123
    emit(encode_addi(5'd2, 5'd1, 12'h456));              // x2 = 0x579
    emit(encode_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));     // add x3 = 0x69c
    emit(encode_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));     // sub x4 = 0x579
    emit(encode_r(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));     // and x5 = 0x418
    emit(encode_r(7'h00, 3'b110, 5'd6, 5'd5, 5'd1));     // or  x6 = 0x53b
    emit(encode_r(7'h00, 3'b100, 5'd7, 5'd6, 5'd3));     // xor x7 = 0x3a7
    emit(encode_r(7'h20, 3'b000, 5'd8, 5'd1, 5'd3));     // sub x8 = -0x579
    emit(encode_addi(5'd9, 5'd7, 12'hFF8));              // x9 = x7 - 8
    emit(encode_sw(5'd3, 5'd0, 12'h200));
    emit(encode_sw(5'd4, 5'd0, 12'h204));
    emit(encode_sw(5'd5, 5'd0, 12'h208));
    emit(encode_sw(5'd6, 5'd0, 12'h20C));
    emit(encode_sw(5'd7, 5'd0, 12'h210));
    emit(encode_sw(5'd8, 5'd0, 12'h214));
    emit(encode_sw(5'd9, 5'd0, 12'h218));
    // Load-use pairs
    emit(encode_lw(5'd10, 5'd0, 12'h100));
    emit(encode_r(7'h00, 3'b000, 5'd11, 5'd10, 5'd1));
    emit(encode_sw(5'd11, 5'd0, 12'h21C));
    emit(encode_sw(5'd10, 5'd0, 12'h220));
    emit(encode_lw(5'd12, 5'd0, 12'h104));
    emit(encode_sw(5'd12, 5'd0, 12'h224));
    // Taken branches skip two marker stores each
    emit(encode_branch(3'b000, 5'd4, 5'd2, 13'd12));
    emit(encode_sw(5'd1, 5'd0, 12'h300));
    emit(encode_sw(5'd1, 5'd0, 12'h304));
    emit(encode_branch(3'b001, 5'd1, 5'd3, 13'd12));
    emit(encode_sw(5'd1, 5'd0, 12'h308));
    emit(encode_sw(5'd1, 5'd0, 12'h30C));
    emit(encode_branch(3'b000, 5'd1, 5'd3, 13'd8));      // Not taken
    emit(encode_sw(5'd1, 5'd0, 12'h228));
    emit(encode_branch(3'b001, 5'd4, 5'd2, 13'd8));      // Not taken
    emit(encode_sw(5'd2, 5'd0, 12'h22C));
    illegal_pc = BOOT_ADDRESS + 32'(prog_len * 4);
    emit(32'hFFFF_FFFF);
    emit(NOP);
    unaligned_pc = BOOT_ADDRESS + 32'(prog_len * 4);
    emit(encode_sw(5'd1, 5'd0, 12'h102));
    emit(encode_sw(5'd9, 5'd0, 12'h230));
    emit(32'h0000_0073);                                 // ecall

    expect_word(32'h200, 32'h0000_069C);
    expect_word(32'h204, 32'h0000_0579);
    expect_word(32'h208, 32'h0000_0418);
    expect_word(32'h20C, 32'h0000_053B);
    expect_word(32'h210, 32'h0000_03A7);
    expect_word(32'h214, 32'hFFFF_FA87);
    expect_word(32'h218, 32'h0000_039F);
    expect_word(32'h21C, fill_word(32'h100) + 32'h0000_0123);
    expect_word(32'h220, fill_word(32'h100));
    expect_word(32'h224, fill_word(32'h104));
    expect_word(32'h228, 32'h0000_0123);
    expect_word(32'h22C, 32'h0000_0579);
    expect_word(32'h230, 32'h0000_039F);
    forbid_words = '{32'h100, 32'h300, 32'h304, 32'h308, 32'h30C};
    foreach (forbid_words[j])
        expect_word(forbid_words[j], fill_word(forbid_words[j]));
endtask

`endif

// File: dv/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    localparam core_pkg::addr_t BOOT_ADDRESS = 32'h0000_1000;
    localparam int CLK_PERIOD       = 100;
    localparam int RESET_CYCLES     = 8;
    localparam int CYCLES_PER_INSTR = 40;
    localparam int IMEM_WORDS       = 64;
    localparam int DMEM_WORDS       = 256;
    localparam logic [31:0] NOP     = 32'h0000_0013;    // addi x0, x0, 0
    localparam logic [1:0] CODE_DECODE = 2'd1;
    localparam logic [1:0] CODE_MEMORY = 2'd3;

    logic clk;
    logic rst;
    core_pkg::addr_t  imem_addr;
    core_pkg::instr_t imem_data;
    logic dmem_en, dmem_wr, dmem_done;
    core_pkg::addr_t dmem_addr;
    core_pkg::xlen_t dmem_wdata, dmem_rdata;
    logic ecall;
    core_pkg::addr_t epc;
    isa_pkg::cause_e cause;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] forbid_words [5];                      // Words no store may touch
    logic [31:0] imem_idx;
    core_pkg::addr_t illegal_pc, unaligned_pc;
    int   prog_len;
    int   seed;
    int   wait_left;
    logic busy;
    logic seen_decode_trap;

    core #(.BOOT_ADDRESS(BOOT_ADDRESS)) DUT (
        .i_clk(clk), .i_rst(rst), .o_imem_addr(imem_addr), .i_imem_data(imem_data),
        .o_dmem_en(dmem_en), .o_dmem_wr(dmem_wr), .o_dmem_addr(dmem_addr),
        .o_dmem_wdata(dmem_wdata), .i_dmem_rdata(dmem_rdata), .i_dmem_done(dmem_done),
        .o_ecall(ecall), .o_epc(epc), .o_cause(cause)
    );

    task automatic report_value(input string test, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("ERROR %s expected 0x%08h actual 0x%08h", test, expected, actual);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_failure(input string what);
        $display("ERROR %s", what);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // Initial data memory word for a byte address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B9) ^ 32'hA5A5_0F0F;
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] encode_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encode_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                                  input logic [4:0] rs2,
                                                  input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic expect_word(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    function automatic logic is_forbidden(input logic [31:0] addr);
        logic hit;
        hit = 1'b0;
        foreach (forbid_words[k])
            if ({addr[31:2], 2'b00} == forbid_words[k])
                hit = 1'b1;
        return hit;
    endfunction

    `include "core_tb_program.svh"

    task automatic check_results();
        foreach (exp_addr[k])
            if (dmem[exp_addr[k][9:2]] !== exp_data[k])
                report_value($sformatf("dmem[0x%03h]", exp_addr[k]), exp_data[k],
                             dmem[exp_addr[k][9:2]]);
        if (!seen_decode_trap)
            report_failure("the illegal instruction trap was never recorded");
    endtask

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Instruction fetch answers in the same cycle
    assign imem_idx  = (imem_addr - BOOT_ADDRESS) >> 2;
    assign imem_data = (imem_idx < IMEM_WORDS) ? imem[imem_idx[5:0]] : NOP;

    always @(posedge clk)
    begin
        if (!rst && dmem_en && dmem_done && dmem_wr)
            dmem[dmem_addr[9:2]] <= dmem_wdata;
    end

    // Data port with a random 0 to 3 cycle wait
    always @(posedge clk)
    begin
        #10;
        if (!rst)
        begin
            if (dmem_done)
            begin
                dmem_done = 1'b0;                       // Request finished at this edge
                busy      = 1'b0;
            end
            if (dmem_en && !busy)
            begin
                busy      = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;
            end
            if (busy && wait_left == 0)
            begin
                dmem_done  = 1'b1;
                dmem_rdata = dmem[dmem_addr[9:2]];
            end
            else if (busy)
                wait_left--;
        end
    end

    always @(posedge clk)
    begin
        if (!rst && epc == illegal_pc && cause == CODE_DECODE)
            seen_decode_trap <= 1'b1;
    end

    a_reset_fetch: assert property (@(posedge clk) rst |-> imem_addr == BOOT_ADDRESS)
        else report_value("reset_fetch", BOOT_ADDRESS, imem_addr);
    a_reset_idle: assert property (@(posedge clk) (rst || $fell(rst)) |-> !dmem_en && !ecall)
        else report_value("reset_idle", 32'd0, {30'd0, dmem_en, ecall});
    a_first_fetch: assert property (@(posedge clk) $fell(rst) |-> imem_addr == BOOT_ADDRESS)
        else report_value("first_fetch", BOOT_ADDRESS, imem_addr);
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        dmem_en && !dmem_done |=> dmem_en && $stable(dmem_addr) && $stable(dmem_wr) &&
                                  $stable(dmem_wdata))
        else report_failure("data request changed while waiting for done");
    a_no_marker_write: assert property (@(posedge clk) disable iff (rst)
        dmem_en && dmem_wr |-> !is_forbidden(dmem_addr))
        else report_failure($sformatf("store reached protected address 0x%08h", dmem_addr));
    a_decode_cause: assert property (@(posedge clk) disable iff (rst)
        epc == illegal_pc |-> cause == CODE_DECODE)
        else report_value("decode_trap_cause", {30'd0, CODE_DECODE}, {30'd0, cause});
    a_ecall_epc: assert property (@(posedge clk) disable iff (rst)
        ecall |-> epc == unaligned_pc)
        else report_value("ecall_epc", unaligned_pc, epc);
    a_ecall_cause: assert property (@(posedge clk) disable iff (rst)
        ecall |-> cause == CODE_MEMORY)
        else report_value("ecall_cause", {30'd0, CODE_MEMORY}, {30'd0, cause});
    a_ecall_pulse: assert property (@(posedge clk) disable iff (rst) ecall |=> !ecall)
        else report_failure("ecall stayed high for more than one cycle");

    initial
    begin
        int i;
        clk              = 1'b0;
        rst              = 1'b0;
        dmem_done        = 1'b0;
        dmem_rdata       = '0;
        busy             = 1'b0;
        wait_left        = 0;
        seed             = 32'he29b;
        seen_decode_trap = 1'b0;
        for (i = 0; i < DMEM_WORDS; i++)
            dmem[i] = fill_word(32'(i * 4));
        load_program();
        #5;
        rst = 1'b1;                                     // Rising edge triggers the async reset
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst = 1'b0;
        wait (ecall === 1'b1);
        // One edge samples the pulse, the next sees it gone
        repeat (2) @(posedge clk);
        #1;
        check_results();
        $display("TESTS PASSED");
        $finish;
    end

    initial
    begin
        #1;
        #((RESET_CYCLES + prog_len * CYCLES_PER_INSTR) * CLK_PERIOD);
        report_failure("watchdog timeout, ecall never reached write-back");
    end

endmodule

// File: sim.f
+incdir+dv
hdl/core_pkg.sv
hdl/isa_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/hazard_unit.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/core.sv
dv/core_tb.sv

// File: Makefile
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard hdl/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
